/* source/busPkg.sv */
// Processor bus types
// One access as the CPU drives it onto the pins

package busPkg;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Basic bus widths
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Full 16-bit processor address
    typedef logic [15:0] addr_t;

    // One byte on the data bus
    typedef logic [7:0] data_t;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus access as seen on the pins
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Strobes are active low, Z80 style
    // nMreq selects memory space, nIorq selects IO space
    // nRd and nWr give the direction
    // No wait, interrupt or bus request pins here
    typedef struct packed {
        addr_t addr;
        // Only meaningful while nWr is low
        data_t wrData;
        logic  nMreq;
        logic  nIorq;
        logic  nRd;
        logic  nWr;
    } busReq_t;

endpackage

/* source/periphPkg.sv */
// Memory and IO map of the host board
// Decoded access and the fixed reply bytes

package periphPkg;

    import busPkg::*;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Access targets
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Unit reached by a decoded access
    // tgtNone also covers idle cycles
    typedef enum logic [1:0] {
        tgtNone,
        tgtRam,
        tgtUartData,
        tgtUartStatus
    } target_t;

    // Decoded access, one per clock
    // isRead and isWrite are never both set
    typedef struct packed {
        target_t target;
        logic    isRead;
        logic    isWrite;
        // Memory space when set, IO space otherwise
        logic    isMem;
        addr_t   offset;
        data_t   wrData;
    } access_t;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // IO map and fixed reply bytes
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Port page is the high address byte
    // Page 00 takes serial transmit data
    localparam data_t ioDataPage   = 8'h00;
    // Page 02 returns the transmitter busy flag
    localparam data_t ioStatusPage = 8'h02;

    // IO read that hits nothing
    localparam data_t idleIoByte   = 8'h80;
    // Memory read above the RAM window
    localparam data_t unmappedByte = 8'hFF;

endpackage

/* source/busDecode.sv */
`timescale 1ns/10ps

// Decode stage
// Strobes and address in, classified access out
module busDecode #(
    parameter int ramAddrBits = 14
) (
    input  busPkg::busReq_t    busReq,
    output periphPkg::access_t access
);

    import periphPkg::*;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Strobe check
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic       dirOk;
    logic       spaceOk;
    logic       active;
    logic       inRamWindow;
    logic [7:0] ioPage;

    // Exactly one direction strobe low
    assign dirOk   = busReq.nRd ^ busReq.nWr;
    // Exactly one space strobe low
    assign spaceOk = busReq.nMreq ^ busReq.nIorq;
    // Anything else counts as idle
    assign active  = dirOk & spaceOk;

    // RAM sits at the bottom of memory space
    assign inRamWindow = (busReq.addr >> ramAddrBits) == '0;

    // Port page from the upper address byte
    assign ioPage = busReq.addr[15:8];

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Classify
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        access.isRead  = active & ~busReq.nRd;
        access.isWrite = active & ~busReq.nWr;
        access.isMem   = active & ~busReq.nMreq;
        // Address and data ride along untouched
        access.offset  = busReq.addr;
        access.wrData  = busReq.wrData;
        access.target  = tgtNone;

        if (active) begin
            if (access.isMem) begin
                // Memory space, RAM window only
                if (inRamWindow) begin
                    access.target = tgtRam;
                end
            end else begin
                // IO space
                if (access.isWrite && ioPage == ioDataPage) begin
                    access.target = tgtUartData;
                end else if (access.isRead && ioPage == ioStatusPage) begin
                    access.target = tgtUartStatus;
                end
            end
        end
    end

endmodule

/* source/hostRam.sv */
`timescale 1ns/10ps

// Execute stage, RAM
// Synchronous write, registered read
module hostRam #(
    parameter int ramAddrBits = 14
) (
    input  logic               clk,
    input  logic               rstN,
    input  periphPkg::access_t access,
    output busPkg::data_t      ramData
);

    import busPkg::*;
    import periphPkg::*;

    localparam int ramBytes = 1 << ramAddrBits;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Storage
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    data_t                  mem [ramBytes];
    logic [ramAddrBits-1:0] ramAddr;
    logic                   ramWe;

    // Low address bits index the window
    assign ramAddr = access.offset[ramAddrBits-1:0];

    // Write strobe, decode already checked the window
    assign ramWe = access.isWrite && access.target == tgtRam;

    // Write lands on the sampling edge
    always_ff @(posedge clk) begin
        if (ramWe) begin
            mem[ramAddr] <= access.wrData;
        end
    end

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read port
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Byte at the offset every cycle
    // readMux decides whether it is wanted
    always_ff @(posedge clk) begin
        if (!rstN) begin
            ramData <= '0;
        end else begin
            ramData <= mem[ramAddr];
        end
    end

endmodule

/* source/uartTx.sv */
`timescale 1ns/10ps

// Execute stage, serial transmitter
// 8N1 frame, LSB first, busy while a frame is out
module uartTx #(
    parameter int clksPerBit = 8
) (
    input  logic               clk,
    input  logic               rstN,
    input  periphPkg::access_t access,
    output logic               busy,
    output logic               uartTx
);

    import periphPkg::*;

    // At least one bit of timer, even for one clock per bit
    localparam int timerBits = (clksPerBit > 1) ? $clog2(clksPerBit) : 1;
    localparam logic [timerBits-1:0] lastTick = timerBits'(clksPerBit - 1);
    // Start, eight data, stop
    localparam logic [3:0] lastBit = 4'd9;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Frame state
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic [9:0]           shiftReg;
    logic [timerBits-1:0] bitTimer;
    logic [3:0]           bitCount;
    logic                 accept;
    logic                 bitDone;

    // Data write taken only when idle, dropped otherwise
    assign accept = access.target == tgtUartData && access.isWrite && !busy;

    // Last clock of the current bit
    assign bitDone = bitTimer == lastTick;

    // Line is bit 0 of the shifter
    // Ones shift in behind the frame so idle is high
    assign uartTx = shiftReg[0];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            busy     <= 1'b0;
            shiftReg <= '1;
            bitTimer <= '0;
            bitCount <= '0;
        end else if (accept) begin
            // Stop bit, data, start bit at the bottom
            busy     <= 1'b1;
            shiftReg <= {1'b1, access.wrData, 1'b0};
            bitTimer <= '0;
            bitCount <= '0;
        end else if (busy) begin
            if (bitDone) begin
                bitTimer <= '0;
                shiftReg <= {1'b1, shiftReg[9:1]};
                if (bitCount == lastBit) begin
                    // End of stop bit
                    busy     <= 1'b0;
                    bitCount <= '0;
                end else begin
                    bitCount <= bitCount + 4'd1;
                end
            end else begin
                bitTimer <= bitTimer + 1'b1;
            end
        end
    end

endmodule

/* source/readMux.sv */
`timescale 1ns/10ps

// Result stage
// Forms the byte returned for each read
module readMux (
    input  logic               clk,
    input  logic               rstN,
    input  periphPkg::access_t access,
    input  busPkg::data_t      ramData,
    input  logic               busy,
    output busPkg::data_t      rdData
);

    import busPkg::*;
    import periphPkg::*;

    data_t replyReg;
    data_t replyNext;
    // Last sampled read went to RAM
    logic  ramSel;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reply for non-RAM reads
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        if (access.target == tgtUartStatus) begin
            replyNext = {7'b0, busy};
        end else if (access.isMem) begin
            // Memory above the window
            replyNext = unmappedByte;
        end else begin
            replyNext = idleIoByte;
        end
    end

    // RAM byte is already registered in hostRam
    // so only its selection is kept here
    always_ff @(posedge clk) begin
        if (!rstN) begin
            replyReg <= '0;
            ramSel   <= 1'b0;
        end else if (access.isRead) begin
            ramSel <= access.target == tgtRam;
            if (access.target != tgtRam) begin
                replyReg <= replyNext;
            end
        end else if (ramSel) begin
            // Hold the RAM answer once ramData moves on
            replyReg <= ramData;
            ramSel   <= 1'b0;
        end
    end

    assign rdData = ramSel ? ramData : replyReg;

endmodule

/* source/host.sv */
`timescale 1ns/10ps

// Host board top level
// Decode, execute, result for one CPU bus
module host #(
    parameter int ramAddrBits = 14,
    parameter int clksPerBit  = 8
) (
    input  logic             clk,
    input  logic             rstN,
    input  busPkg::busReq_t  busReq,
    output busPkg::data_t    rdData,
    output logic             uartTx
);

    import busPkg::*;
    import periphPkg::*;

    access_t access;
    data_t   ramData;
    logic    busy;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Decode
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    busDecode #(
        .ramAddrBits(ramAddrBits)
    ) busDecode0 (
        .busReq(busReq),
        .access(access)
    );

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Execute
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // RAM at 0000 upwards
    hostRam #(
        .ramAddrBits(ramAddrBits)
    ) hostRam0 (
        .clk    (clk),
        .rstN   (rstN),
        .access (access),
        .ramData(ramData)
    );

    // Data on port page 00, status on page 02
    uartTx #(
        .clksPerBit(clksPerBit)
    ) uartTx0 (
        .clk   (clk),
        .rstN  (rstN),
        .access(access),
        .busy  (busy),
        .uartTx(uartTx)
    );

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Result
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    readMux readMux0 (
        .clk    (clk),
        .rstN   (rstN),
        .access (access),
        .ramData(ramData),
        .busy   (busy),
        .rdData (rdData)
    );

endmodule

/* test/hostBus_assertions.sv */
`timescale 1ns/10ps

// Checker on the serial side of the host top level
module hostBusAssertions #(
    parameter int clksPerBit = 8
) (
    input logic clk,
    input logic rstN,
    input logic busy,
    input logic uartTx
);

    // Start, eight data, stop
    localparam int frameClks = 10 * clksPerBit;

    // Line idles high between frames
    idleLineHigh: assert property (
        @(posedge clk) disable iff (!rstN) !busy |-> uartTx
    ) else $error("serial line low while the transmitter is idle");

    // First cycle out of reset
    busyClearAfterReset: assert property (
        @(posedge clk) $rose(rstN) |-> !busy
    ) else $error("transmitter busy right after reset");

    // Busy covers exactly one frame
    frameLength: assert property (
        @(posedge clk) disable iff (!rstN)
        $fell(busy) |-> $past(busy, frameClks) && !$past(busy, frameClks + 1)
    ) else $error("busy did not last one full frame");

endmodule

bind host hostBusAssertions #(
    .clksPerBit(clksPerBit)
) hostBusAssertions0 (
    .clk   (clk),
    .rstN  (rstN),
    .busy  (busy),
    .uartTx(uartTx)
);

/* test/hostTb.sv */
`timescale 1ns/10ps

module hostTb;

    import busPkg::*;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Map and run sizes
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int clksPerBit = 8;
    localparam int frameClks  = 10 * clksPerBit;
    localparam int ramBytes   = 16384;
    localparam addr_t ramTop  = 16'h4000;
    localparam data_t dataPage   = 8'h00;
    localparam data_t statusPage = 8'h02;
    localparam data_t idleIo     = 8'h80;
    localparam data_t unmapped   = 8'hFF;

    localparam int ramWrites      = 64;
    localparam int unwrittenReads = 16;
    localparam int rawPairs       = 8;
    localparam int unmappedReads  = 16;
    localparam int unmappedWrites = 8;
    localparam int otherIoReads   = 8;
    localparam int polledBytes    = 4;
    // First frame, the one kept while busy, then the polled ones
    localparam int bytesSent      = 2 + polledBytes;
    localparam int plannedAccesses = 1 + 2 * ramWrites + unwrittenReads + 2 * rawPairs
        + unmappedReads + 2 * unmappedWrites + otherIoReads + bytesSent + 2;
    localparam int pollMargin = bytesSent * frameClks + 64;
    localparam int cycleLimit = 2 * (plannedAccesses * 2 + bytesSent * frameClks + pollMargin);

    // All strobes high
    localparam busReq_t idleReq = {16'h0000, 8'h00, 4'b1111};

    logic    clk = 1'b0;
    logic    rstN;
    busReq_t busReq;
    data_t   rdData;
    logic    uartTx;

    integer seed = 32'h23bb;

    // Shadow of RAM
    // known marks bytes written so far
    data_t shadow [ramBytes];
    bit    known [ramBytes];
    addr_t addrList [ramWrites];
    data_t expUart [$];
    int    busyLeft;
    int    framesSeen;
    int    cycleCount;
    logic  pendValid;
    logic  pendStatus;
    logic  pendBusy;
    data_t pendExp;
    data_t rxByte;

    host #(
        .ramAddrBits(14),
        .clksPerBit (clksPerBit)
    ) dut0 (
        .clk   (clk),
        .rstN  (rstN),
        .busReq(busReq),
        .rdData(rdData),
        .uartTx(uartTx)
    );

    always #2 clk = ~clk;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Compare tasks
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic failRun();
        $display("Something failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic checkRead(data_t got, data_t expected);
        if (got !== expected) begin
            $display("Mismatch at %0t: read returned %h, expected %h", $time, got, expected);
            failRun();
        end
    endtask

    task automatic checkUartByte(data_t got, data_t expected);
        if (got !== expected) begin
            $display("Mismatch at %0t: serial byte %h, expected %h", $time, got, expected);
            failRun();
        end
    endtask

    task automatic checkBusy(logic got, logic expected);
        if (got !== expected) begin
            $display("Mismatch at %0t: busy flag %b, expected %b", $time, got, expected);
            failRun();
        end
    endtask

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference rules
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic busReq_t makeReq(addr_t addr, data_t data, logic isMem, logic isWrite);
        busReq_t req;
        req.addr   = addr;
        req.wrData = data;
        req.nMreq  = !isMem;
        req.nIorq  = isMem;
        req.nRd    = isWrite;
        req.nWr    = !isWrite;
        return req;
    endfunction

    // One direction and one space strobe low
    function automatic logic accessActive(busReq_t req);
        return (req.nRd != req.nWr) && (req.nMreq != req.nIorq);
    endfunction

    // Reply byte for an active read
    // Busy is taken as seen at the sampling edge
    function automatic data_t expectedRead(busReq_t req);
        if (!req.nMreq) begin
            if (req.addr < ramTop) begin
                return shadow[req.addr[13:0]];
            end
            return unmapped;
        end
        if (req.addr[15:8] == statusPage) begin
            return {7'b0, busyLeft != 0};
        end
        return idleIo;
    endfunction

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // CPU bus driver
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // One access cycle, then one idle cycle
    task automatic busAccess(busReq_t req);
        @(posedge clk);
        #1;
        busReq = req;
        @(posedge clk);
        #1;
        busReq = idleReq;
    endtask

    task automatic writeMem(addr_t addr, data_t data);
        if (addr < ramTop) begin
            shadow[addr[13:0]] = data;
            known[addr[13:0]]  = 1'b1;
        end
        busAccess(makeReq(addr, data, 1'b1, 1'b1));
    endtask

    // Answer is on rdData one cycle after the sampling edge
    task automatic readMem(addr_t addr, output data_t got);
        busAccess(makeReq(addr, 8'h00, 1'b1, 1'b0));
        got = rdData;
    endtask

    task automatic writeIo(addr_t addr, data_t data);
        busAccess(makeReq(addr, data, 1'b0, 1'b1));
    endtask

    task automatic readIo(addr_t addr, output data_t got);
        busAccess(makeReq(addr, 8'h00, 1'b0, 1'b0));
        got = rdData;
    endtask

    // Poll status until the transmitter is free
    task automatic waitIdle();
        data_t status;
        status = 8'h01;
        while (status[0]) begin
            readIo({statusPage, 8'h00}, status);
        end
    endtask

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Model and comparing process
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(posedge clk) begin
        logic accepted;
        if (!rstN) begin
            busyLeft  = 0;
            pendValid = 1'b0;
        end else begin
            pendValid  = 1'b0;
            pendStatus = 1'b0;
            if (accessActive(busReq) && !busReq.nRd) begin
                // Unwritten RAM has no known answer
                if (busReq.nMreq || busReq.addr >= ramTop || known[busReq.addr[13:0]]) begin
                    pendValid  = 1'b1;
                    pendExp    = expectedRead(busReq);
                    pendStatus = !busReq.nIorq && busReq.addr[15:8] == statusPage;
                    pendBusy   = busyLeft != 0;
                end
            end
            // Data write taken only while idle
            accepted = accessActive(busReq) && !busReq.nWr && !busReq.nIorq
                && busReq.addr[15:8] == dataPage && busyLeft == 0;
            if (busyLeft > 0) begin
                busyLeft = busyLeft - 1;
            end
            if (accepted) begin
                busyLeft = frameClks;
                expUart.push_back(busReq.wrData);
            end
        end
    end

    // rdData is stable mid-cycle after the sampling edge
    always @(negedge clk) begin
        if (pendValid) begin
            if (pendStatus) begin
                checkBusy(rdData[0], pendBusy);
            end
            checkRead(rdData, pendExp);
        end
    end

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Serial monitor and timeout
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always begin
        @(negedge uartTx);
        if (rstN === 1'b1) begin
            // Middle of the start bit
            repeat (clksPerBit / 2) @(negedge clk);
            if (uartTx !== 1'b0) begin
                $display("Start bit on the serial line was too short");
                failRun();
            end
            for (int i = 0; i < 8; i++) begin
                repeat (clksPerBit) @(negedge clk);
                rxByte[i] = uartTx;
            end
            repeat (clksPerBit) @(negedge clk);
            if (uartTx !== 1'b1) begin
                $display("Serial frame has no stop bit");
                failRun();
            end
            if (expUart.size() == 0) begin
                $display("Serial frame appeared with no byte sent");
                failRun();
            end
            checkUartByte(rxByte, expUart.pop_front());
            framesSeen = framesSeen + 1;
        end
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            failRun();
        end
    end

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        data_t got;
        addr_t addr;
        data_t data;
        busReq     = idleReq;
        rstN       = 1'b0;
        busyLeft   = 0;
        framesSeen = 0;
        cycleCount = 0;
        pendValid  = 1'b0;
        pendStatus = 1'b0;
        pendBusy   = 1'b0;
        pendExp    = 8'h00;
        repeat (3) @(posedge clk);
        #1;
        rstN = 1'b1;

        // Reset state
        if (uartTx !== 1'b1) begin
            $display("Serial line is not high after reset");
            failRun();
        end
        checkRead(rdData, 8'h00);
        readIo({statusPage, 8'h00}, got);
        checkBusy(got[0], 1'b0);

        // RAM writes, read back, then unwritten reads
        for (int i = 0; i < ramWrites; i++) begin
            addr = 16'($random(seed)) & 16'h3FFF;
            addrList[i] = addr;
            writeMem(addr, 8'($random(seed)));
        end
        for (int i = 0; i < ramWrites; i++) begin
            readMem(addrList[i], got);
        end
        for (int i = 0; i < unwrittenReads; i++) begin
            readMem(16'($random(seed)) & 16'h3FFF, got);
        end
        // Read straight after a write
        for (int i = 0; i < rawPairs; i++) begin
            addr = 16'($random(seed)) & 16'h3FFF;
            data = 8'($random(seed));
            writeMem(addr, data);
            readMem(addr, got);
            checkRead(got, data);
        end

        // Memory above the window
        // Writes there must not alias into RAM
        for (int i = 0; i < unmappedReads; i++) begin
            readMem(16'($random(seed)) | ramTop, got);
            checkRead(got, unmapped);
        end
        for (int i = 0; i < unmappedWrites; i++) begin
            writeMem(addrList[i] | ramTop, 8'($random(seed)));
            readMem(addrList[i], got);
            checkRead(got, shadow[addrList[i][13:0]]);
        end
        // IO pages without a register
        for (int i = 0; i < otherIoReads; i++) begin
            data = 8'($random(seed));
            if (data == statusPage) begin
                data = 8'h03;
            end
            readIo({data, 8'($random(seed))}, got);
            checkRead(got, idleIo);
        end

        // One frame with busy set during it and clear after
        writeIo({dataPage, 8'h12}, 8'($random(seed)));
        readIo({statusPage, 8'h00}, got);
        checkBusy(got[0], 1'b1);
        waitIdle();
        if (framesSeen != 1) begin
            $display("Expected one serial frame, saw %0d", framesSeen);
            failRun();
        end

        // Second write lands while busy and is dropped
        data = 8'($random(seed));
        writeIo({dataPage, 8'h00}, data);
        writeIo({dataPage, 8'h00}, ~data);
        waitIdle();
        if (framesSeen != 2) begin
            $display("Write while busy was not dropped, %0d frames seen", framesSeen);
            failRun();
        end
        for (int i = 0; i < polledBytes; i++) begin
            waitIdle();
            writeIo({dataPage, 8'($random(seed))}, 8'($random(seed)));
        end
        waitIdle();
        repeat (4) @(posedge clk);

        if (expUart.size() == 0 && framesSeen == bytesSent) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("Serial bytes missing, %0d frames seen of %0d", framesSeen, bytesSent);
            failRun();
        end
    end

endmodule

/* hostBus.f */
source/busPkg.sv
source/periphPkg.sv
source/busDecode.sv
source/hostRam.sv
source/uartTx.sv
source/readMux.sv
source/host.sv
test/hostBus_assertions.sv
test/hostTb.sv

/* run.sh */
#!/bin/sh
# Compile and run the host testbench with Verilator

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --assert --top-module hostTb -f hostBus.f -o hostTbSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/hostTbSim > "$logFile" 2>&1
simStatus=$?
cat "$logFile"

if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

# The testbench reports any failure in the log
if grep -q "Something failed" "$logFile"; then
    echo "Test failed"
    exit 1
fi

echo "Test passed"
exit 0
